// File: rtl/vc_router_pkg.sv
/*
 * sizing and flit types shared by every block of the VC router stage
 * the downstream buffer is assumed to be VCDepth deep per VC, so the credit
 * counters start at VCDepth and CreditWidth must be able to hold it
 */
`default_nettype none

package vc_router_pkg;

  // router shape
  localparam int NumInPorts = 2;
  localparam int NumVC = 2;
  localparam int NumVCWidth = 1;

  // buffering and credits
  localparam int VCDepth = 3;
  localparam int CreditWidth = 2;

  // flit fields
  localparam int PayloadWidth = 16;
  localparam int SeqWidth = 7;

  // allocator request space, one request per (port, VC)
  localparam int NumReq = NumInPorts * NumVC;
  localparam int ReqIdxWidth = (NumReq > 1) ? $clog2(NumReq) : 1;
  localparam int PortIdxWidth = (NumInPorts > 1) ? $clog2(NumInPorts) : 1;

  // seq is set by the source and only carried through
  typedef struct packed {
    logic [NumVCWidth-1:0] vc_id;
    logic [SeqWidth-1:0]   seq;
  } hdr_t;

  typedef logic [PayloadWidth-1:0] payload_t;

  // header sits above the payload
  typedef struct packed {
    hdr_t     hdr;
    payload_t payload;
  } flit_t;

endpackage

`default_nettype wire

// File: rtl/port_alloc_if.sv
/*
 * head view and pop controls between one input port and the switch allocator
 * one instance per input port
 */
`default_nettype none

interface port_alloc_if;

  // head of every VC, driven by the input port
  logic [vc_router_pkg::NumVC-1:0]                         head_v;
  vc_router_pkg::hdr_t [vc_router_pkg::NumVC-1:0]          head_hdr;
  vc_router_pkg::payload_t [vc_router_pkg::NumVC-1:0]      head_data;

  // header pop in SA, payload pop in ST
  logic                                                    sa_pop;
  logic [vc_router_pkg::NumVC-1:0]                         sa_vc_oh;
  logic                                                    st_pop;
  logic [vc_router_pkg::NumVC-1:0]                         st_vc_oh;

  modport port (
    output head_v, head_hdr, head_data,
    input  sa_pop, sa_vc_oh, st_pop, st_vc_oh
  );

  modport alloc (
    input  head_v, head_hdr, head_data,
    output sa_pop, sa_vc_oh, st_pop, st_vc_oh
  );

endinterface

`default_nettype wire

// File: rtl/vc_fifo.sv
/*
 * small circular FIFO with a type parameter for the stored word
 * data_o is the head and is only meaningful while valid_o is high
 * a push when full is accepted only together with a pop
 */
`default_nettype none

module vc_fifo #(
  parameter type data_t = logic,
  parameter int  Depth  = 3
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  push_i,
  input  data_t data_i,
  input  logic  pop_i,
  output data_t data_o,
  output logic  valid_o,
  output logic  full_o
);

  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth = $clog2(Depth + 1);

  data_t               mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push_en;
  logic                pop_en;

  assign valid_o = (count_q != '0);
  assign full_o  = (int'(count_q) == Depth);
  assign pop_en  = pop_i && valid_o;
  assign push_en = push_i && (!full_o || pop_en);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (int'(wr_ptr_q) == Depth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (int'(rd_ptr_q) == Depth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_en, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage only, the pointers say what is valid
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // the sender must honour its credits
  assert property (@(posedge clk_i) disable iff (!rst_n_i) (push_i && full_o) |-> pop_i)
    else $error("vc_fifo push while full");

  assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> valid_o)
    else $error("vc_fifo pop while empty");

endmodule

`default_nettype wire

// File: rtl/vc_input_port.sv
/*
 * one input port with a header FIFO and a payload FIFO per VC
 * headers leave in SA, payloads in ST, and the upstream credit goes back in ST
 * the sender may only push into a VC while it holds a credit for it
 */
`default_nettype none

module vc_input_port (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 in_valid_i,
  input  vc_router_pkg::flit_t                 in_flit_i,
  output logic                                 credit_v_o,
  output logic [vc_router_pkg::NumVCWidth-1:0] credit_id_o,
  port_alloc_if.port                           alloc_bus
);

  logic [vc_router_pkg::NumVC-1:0]                    push_oh;
  logic [vc_router_pkg::NumVC-1:0]                    hdr_pop;
  logic [vc_router_pkg::NumVC-1:0]                    data_pop;
  logic [vc_router_pkg::NumVC-1:0]                    hdr_valid;
  vc_router_pkg::hdr_t [vc_router_pkg::NumVC-1:0]     hdr_head;
  vc_router_pkg::payload_t [vc_router_pkg::NumVC-1:0] data_head;

  // steer the incoming flit to the VC named in its header
  always_comb begin
    push_oh = '0;
    if (in_valid_i) begin
      push_oh[in_flit_i.hdr.vc_id] = 1'b1;
    end
  end

  // pops come from two different pipeline stages
  assign hdr_pop  = alloc_bus.sa_pop ? alloc_bus.sa_vc_oh : '0;
  assign data_pop = alloc_bus.st_pop ? alloc_bus.st_vc_oh : '0;

  for (genvar v = 0; v < vc_router_pkg::NumVC; v++) begin : gen_vc
    vc_fifo #(
      .data_t (vc_router_pkg::hdr_t),
      .Depth  (vc_router_pkg::VCDepth)
    ) u_hdr_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (push_oh[v]),
      .data_i  (in_flit_i.hdr),
      .pop_i   (hdr_pop[v]),
      .data_o  (hdr_head[v]),
      .valid_o (hdr_valid[v]),
      .full_o  ()
    );

    // payload stays behind until its header has won SA
    vc_fifo #(
      .data_t (vc_router_pkg::payload_t),
      .Depth  (vc_router_pkg::VCDepth)
    ) u_data_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (push_oh[v]),
      .data_i  (in_flit_i.payload),
      .pop_i   (data_pop[v]),
      .data_o  (data_head[v]),
      .valid_o (),
      .full_o  ()
    );
  end

  assign alloc_bus.head_v    = hdr_valid;
  assign alloc_bus.head_hdr  = hdr_head;
  assign alloc_bus.head_data = data_head;

  // a payload slot frees up in ST, so the credit goes back then
  assign credit_v_o = alloc_bus.st_pop;

  always_comb begin
    credit_id_o = '0;
    for (int v = 0; v < vc_router_pkg::NumVC; v++) begin
      if (alloc_bus.st_vc_oh[v]) begin
        credit_id_o = credit_id_o | vc_router_pkg::NumVCWidth'(v);
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alloc_bus.st_pop |-> $onehot(alloc_bus.st_vc_oh))
    else $error("vc_input_port ST select is not one-hot");

endmodule

`default_nettype wire

// File: rtl/vc_switch_alloc.sv
/*
 * round-robin switch allocator over every (port, VC) pair
 * a VC requests only while it has a header and a downstream credit
 * one grant per cycle, its payload is muxed out in the following cycle
 */
`default_nettype none

module vc_switch_alloc (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic [vc_router_pkg::NumVC-1:0]      credit_avail_i,
  output logic                                 sa_grant_v_o,
  output logic [vc_router_pkg::NumVCWidth-1:0] sa_grant_vc_o,
  output logic                                 st_valid_o,
  output vc_router_pkg::flit_t                 st_flit_o,
  port_alloc_if.alloc                          port_bus [vc_router_pkg::NumInPorts]
);

  logic [vc_router_pkg::NumReq-1:0]                   req;
  logic [vc_router_pkg::NumInPorts-1:0]               sa_pop;
  vc_router_pkg::hdr_t [vc_router_pkg::NumVC-1:0]     head_hdr [vc_router_pkg::NumInPorts];
  vc_router_pkg::payload_t [vc_router_pkg::NumVC-1:0] head_data [vc_router_pkg::NumInPorts];

  // SA stage
  logic                                   grant_v;
  logic [vc_router_pkg::ReqIdxWidth-1:0]  grant_idx;
  logic [vc_router_pkg::PortIdxWidth-1:0] grant_port;
  logic [vc_router_pkg::NumVCWidth-1:0]   grant_vc;
  logic [vc_router_pkg::NumVC-1:0]        grant_vc_oh;
  logic [vc_router_pkg::ReqIdxWidth-1:0]  rr_q;

  // ST stage
  logic                                   st_v_q;
  logic [vc_router_pkg::PortIdxWidth-1:0] st_port_q;
  logic [vc_router_pkg::NumVCWidth-1:0]   st_vc_q;
  logic [vc_router_pkg::NumVC-1:0]        st_vc_oh;
  vc_router_pkg::hdr_t                    st_hdr_q;

  for (genvar p = 0; p < vc_router_pkg::NumInPorts; p++) begin : gen_port
    assign req[p*vc_router_pkg::NumVC +: vc_router_pkg::NumVC] =
      port_bus[p].head_v & credit_avail_i;
    assign head_hdr[p]  = port_bus[p].head_hdr;
    assign head_data[p] = port_bus[p].head_data;

    assign sa_pop[p]             = grant_v && (int'(grant_port) == p);
    assign port_bus[p].sa_pop    = sa_pop[p];
    assign port_bus[p].sa_vc_oh  = grant_vc_oh;
    assign port_bus[p].st_pop    = st_v_q && (int'(st_port_q) == p);
    assign port_bus[p].st_vc_oh  = st_vc_oh;
  end

  // first request at or after the pointer wins
  always_comb begin
    int idx;
    grant_v   = 1'b0;
    grant_idx = '0;
    for (int i = 0; i < vc_router_pkg::NumReq; i++) begin
      idx = (int'(rr_q) + i) % vc_router_pkg::NumReq;
      if (!grant_v && req[idx]) begin
        grant_v   = 1'b1;
        grant_idx = vc_router_pkg::ReqIdxWidth'(idx);
      end
    end
  end

  assign grant_port = vc_router_pkg::PortIdxWidth'(int'(grant_idx) / vc_router_pkg::NumVC);
  assign grant_vc   = vc_router_pkg::NumVCWidth'(int'(grant_idx) % vc_router_pkg::NumVC);

  always_comb begin
    for (int v = 0; v < vc_router_pkg::NumVC; v++) begin
      grant_vc_oh[v] = (int'(grant_vc) == v);
      st_vc_oh[v]    = (int'(st_vc_q) == v);
    end
  end

  // downstream credit is spent as soon as the grant is made
  assign sa_grant_v_o  = grant_v;
  assign sa_grant_vc_o = grant_vc;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q      <= '0;
      st_v_q    <= 1'b0;
      st_port_q <= '0;
      st_vc_q   <= '0;
    end else begin
      st_v_q <= grant_v;
      if (grant_v) begin
        rr_q      <= (int'(grant_idx) == vc_router_pkg::NumReq - 1) ? '0 : grant_idx + 1'b1;
        st_port_q <= grant_port;
        st_vc_q   <= grant_vc;
      end
    end
  end

  // header is gone from its FIFO after SA, so keep a copy for ST
  always_ff @(posedge clk_i) begin
    if (grant_v) begin
      st_hdr_q <= head_hdr[grant_port][grant_vc];
    end
  end

  assign st_valid_o = st_v_q;
  assign st_flit_o  = '{hdr: st_hdr_q, payload: head_data[st_port_q][st_vc_q]};

  assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(sa_pop))
    else $error("vc_switch_alloc more than one port popped in SA");

endmodule

`default_nettype wire

// File: rtl/vc_output_port.sv
/*
 * output link register and one downstream credit counter per VC
 * counters start at VCDepth and are spent at the SA grant
 * the downstream side must never return more credits than it was given
 */
`default_nettype none

module vc_output_port (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 st_valid_i,
  input  vc_router_pkg::flit_t                 st_flit_i,
  input  logic                                 sa_grant_v_i,
  input  logic [vc_router_pkg::NumVCWidth-1:0] sa_grant_vc_i,
  input  logic                                 down_credit_v_i,
  input  logic [vc_router_pkg::NumVCWidth-1:0] down_credit_id_i,
  output logic [vc_router_pkg::NumVC-1:0]      credit_avail_o,
  output logic                                 out_valid_o,
  output vc_router_pkg::flit_t                 out_flit_o
);

  logic                 out_valid_q;
  vc_router_pkg::flit_t out_flit_q;

  for (genvar v = 0; v < vc_router_pkg::NumVC; v++) begin : gen_credit
    logic                                  spend;
    logic                                  refill;
    logic [vc_router_pkg::CreditWidth-1:0] credit_q;

    assign spend  = sa_grant_v_i && (int'(sa_grant_vc_i) == v);
    assign refill = down_credit_v_i && (int'(down_credit_id_i) == v);

    // spend and refill in the same cycle cancel out
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        credit_q <= vc_router_pkg::CreditWidth'(vc_router_pkg::VCDepth);
      end else if (spend && !refill) begin
        credit_q <= credit_q - 1'b1;
      end else if (refill && !spend) begin
        credit_q <= credit_q + 1'b1;
      end
    end

    assign credit_avail_o[v] = (credit_q != '0);

    assert property (@(posedge clk_i) disable iff (!rst_n_i) spend |-> (credit_q != '0))
      else $error("vc_output_port credit underflow on VC %0d", v);

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (refill && !spend) |-> (int'(credit_q) < vc_router_pkg::VCDepth))
      else $error("vc_output_port credit overflow on VC %0d", v);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= st_valid_i;
    end
  end

  // link data only changes with a new flit
  always_ff @(posedge clk_i) begin
    if (st_valid_i) begin
      out_flit_q <= st_flit_i;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_flit_o  = out_flit_q;

endmodule

`default_nettype wire

// File: rtl/vc_router.sv
/*
 * VC router stage with NumInPorts input ports sharing a single output link
 * no routing, every flit is allocated on its own
 * upstream and downstream both use valid plus credit flow control
 */
`default_nettype none

module vc_router (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // upstream side, one entry per input port
  input  logic                                 in_valid_i      [vc_router_pkg::NumInPorts],
  input  vc_router_pkg::flit_t                 in_flit_i       [vc_router_pkg::NumInPorts],
  output logic                                 in_credit_v_o   [vc_router_pkg::NumInPorts],
  output logic [vc_router_pkg::NumVCWidth-1:0] in_credit_id_o  [vc_router_pkg::NumInPorts],
  // downstream side
  output logic                                 out_valid_o,
  output vc_router_pkg::flit_t                 out_flit_o,
  input  logic                                 out_credit_v_i,
  input  logic [vc_router_pkg::NumVCWidth-1:0] out_credit_id_i
);

  logic                                 st_valid;
  vc_router_pkg::flit_t                 st_flit;
  logic                                 sa_grant_v;
  logic [vc_router_pkg::NumVCWidth-1:0] sa_grant_vc;
  logic [vc_router_pkg::NumVC-1:0]      credit_avail;

  port_alloc_if port_bus [vc_router_pkg::NumInPorts] ();

  for (genvar p = 0; p < vc_router_pkg::NumInPorts; p++) begin : gen_in_port
    vc_input_port u_in_port (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .in_valid_i  (in_valid_i[p]),
      .in_flit_i   (in_flit_i[p]),
      .credit_v_o  (in_credit_v_o[p]),
      .credit_id_o (in_credit_id_o[p]),
      .alloc_bus   (port_bus[p])
    );
  end

  // input ports compete for the link here
  vc_switch_alloc u_switch_alloc (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .credit_avail_i (credit_avail),
    .sa_grant_v_o   (sa_grant_v),
    .sa_grant_vc_o  (sa_grant_vc),
    .st_valid_o     (st_valid),
    .st_flit_o      (st_flit),
    .port_bus       (port_bus)
  );

  vc_output_port u_out_port (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .st_valid_i       (st_valid),
    .st_flit_i        (st_flit),
    .sa_grant_v_i     (sa_grant_v),
    .sa_grant_vc_i    (sa_grant_vc),
    .down_credit_v_i  (out_credit_v_i),
    .down_credit_id_i (out_credit_id_i),
    .credit_avail_o   (credit_avail),
    .out_valid_o      (out_valid_o),
    .out_flit_o       (out_flit_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_vc_router.sv
/*
 * testbench for the VC router stage, traffic rows are run one after another
 * every row must drain completely, so each row starts with full credits
 * the payload carries port, VC and seq so the scoreboard can find the stream
 */
`default_nettype none

module tb_vc_router;

  // vc = NumVC picks a random VC per flit, count is per selected port
  typedef struct packed {
    logic [1:0] port_mask;
    logic [1:0] vc;
    logic [7:0] count;
    logic [3:0] delay;
    logic       hold;
  } row_t;

  localparam int NumRows = 6;
  localparam int HoldWindow = 30;
  localparam row_t Rows [NumRows] = '{
    '{2'b01, 2'd0, 8'd1,  4'd0, 1'b0},
    '{2'b10, 2'd1, 8'd1,  4'd0, 1'b0},
    '{2'b11, 2'd2, 8'd40, 4'd2, 1'b0},
    '{2'b01, 2'd0, 8'd6,  4'd0, 1'b1},
    '{2'b11, 2'd1, 8'd10, 4'd0, 1'b0},
    '{2'b11, 2'd2, 8'd30, 4'd1, 1'b0}
  };

  logic                                 clk_i = 1'b0;
  logic                                 rst_n_i = 1'b0;
  logic                                 in_valid_i [vc_router_pkg::NumInPorts] = '{default: 1'b0};
  vc_router_pkg::flit_t                 in_flit_i [vc_router_pkg::NumInPorts] = '{default: '0};
  logic                                 in_credit_v_o [vc_router_pkg::NumInPorts];
  logic [vc_router_pkg::NumVCWidth-1:0] in_credit_id_o [vc_router_pkg::NumInPorts];
  logic                                 out_valid_o;
  vc_router_pkg::flit_t                 out_flit_o;
  logic                                 out_credit_v_i = 1'b0;
  logic [vc_router_pkg::NumVCWidth-1:0] out_credit_id_i = '0;

  int   seed = 32'h0206fa99;
  int   cycle = 0;
  int   cycle_limit;
  int   err_data = 0;
  int   err_ctrl = 0;
  int   row_req = 0;
  int   release_req = 0;
  int   row_cur = 0;
  int   rows_done = 0;
  bit   row_active = 1'b0;
  row_t row;
  int   prev_port;
  int   to_send [vc_router_pkg::NumInPorts];
  int   pick_vc [vc_router_pkg::NumInPorts];
  int   src_credit [vc_router_pkg::NumInPorts][vc_router_pkg::NumVC];
  int   seq_next [vc_router_pkg::NumInPorts][vc_router_pkg::NumVC];
  int   sent_cnt [vc_router_pkg::NumInPorts][vc_router_pkg::NumVC];
  int   upcred_cnt [vc_router_pkg::NumInPorts][vc_router_pkg::NumVC];
  bit   cred_pend [vc_router_pkg::NumInPorts];
  int   cred_edge [vc_router_pkg::NumInPorts];
  int   cred_vc [vc_router_pkg::NumInPorts];
  int   held_out [vc_router_pkg::NumVC];
  vc_router_pkg::flit_t exp_q [vc_router_pkg::NumReq][$];
  int   sent_edge_q [vc_router_pkg::NumReq][$];
  int   sink_vc_q [$];
  int   sink_due_q [$];

  vc_router u_vc_router (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .in_valid_i      (in_valid_i),
    .in_flit_i       (in_flit_i),
    .in_credit_v_o   (in_credit_v_o),
    .in_credit_id_o  (in_credit_id_o),
    .out_valid_o     (out_valid_o),
    .out_flit_o      (out_flit_o),
    .out_credit_v_i  (out_credit_v_i),
    .out_credit_id_i (out_credit_id_i)
  );

  always #20 clk_i = ~clk_i;

  // port sits in the top nibble so the scoreboard can recover the source
  function automatic vc_router_pkg::payload_t make_payload(int p, int v, int s);
    return {4'(p), 5'(v), 7'(s)};
  endfunction

  function automatic bit credits_held();
    return row.hold && (release_req != row_cur);
  endfunction

  function automatic bit row_drained();
    bit idle;
    idle = (sink_vc_q.size() == 0);
    for (int p = 0; p < vc_router_pkg::NumInPorts; p++) begin
      idle &= (to_send[p] == 0);
    end
    for (int k = 0; k < vc_router_pkg::NumReq; k++) begin
      idle &= (exp_q[k].size() == 0);
    end
    return idle;
  endfunction

  task automatic init_state();
    for (int p = 0; p < vc_router_pkg::NumInPorts; p++) begin
      to_send[p]   = 0;
      pick_vc[p]   = -1;
      cred_pend[p] = 1'b0;
      for (int v = 0; v < vc_router_pkg::NumVC; v++) begin
        src_credit[p][v] = vc_router_pkg::VCDepth;
        seq_next[p][v]   = 0;
        sent_cnt[p][v]   = 0;
        upcred_cnt[p][v] = 0;
      end
    end
  endtask

  task automatic start_row();
    row_cur = row_req;
    row     = Rows[row_req - 1];
    for (int p = 0; p < vc_router_pkg::NumInPorts; p++) begin
      to_send[p] = row.port_mask[p] ? int'(row.count) : 0;
      pick_vc[p] = -1;
    end
    for (int v = 0; v < vc_router_pkg::NumVC; v++) begin
      held_out[v] = 0;
    end
    prev_port  = -1;
    row_active = 1'b1;
  endtask

  // upstream source, one flit per port and cycle while it holds a credit
  task automatic drive_sources();
    logic                 nv [vc_router_pkg::NumInPorts];
    vc_router_pkg::flit_t nf [vc_router_pkg::NumInPorts];
    vc_router_pkg::flit_t f;
    int                   v;
    bit                   gap;
    nv = '{default: 1'b0};
    nf = in_flit_i;
    for (int p = 0; p < vc_router_pkg::NumInPorts; p++) begin
      if (to_send[p] > 0) begin
        if (pick_vc[p] < 0) begin
          pick_vc[p] = (row.vc < vc_router_pkg::NumVC) ? int'(row.vc) : ($random(seed) & 1);
        end
        v   = pick_vc[p];
        gap = (row.vc >= vc_router_pkg::NumVC) && (($random(seed) & 3) == 0);
        if (src_credit[p][v] > 0 && !gap) begin
          f.hdr.vc_id = vc_router_pkg::NumVCWidth'(v);
          f.hdr.seq   = vc_router_pkg::SeqWidth'(seq_next[p][v]);
          f.payload   = make_payload(p, v, seq_next[p][v]);
          nv[p] = 1'b1;
          nf[p] = f;
          exp_q[p * vc_router_pkg::NumVC + v].push_back(f);
          sent_edge_q[p * vc_router_pkg::NumVC + v].push_back(cycle);
          src_credit[p][v]--;
          seq_next[p][v]++;
          sent_cnt[p][v]++;
          to_send[p]--;
          pick_vc[p] = -1;
        end
      end
    end
    in_valid_i <= nv;
    in_flit_i  <= nf;
  endtask

  task automatic score_output();
    vc_router_pkg::flit_t got;
    int                   p;
    int                   vc;
    int                   k;
    got = out_flit_o;
    p   = int'(got.payload[15:12]);
    vc  = int'(got.hdr.vc_id);
    k   = p * vc_router_pkg::NumVC + vc;
    assert (p < vc_router_pkg::NumInPorts) else begin
      err_data++;
      $display("[FAIL] %0t: flit %h names no valid source port", $time, got);
      return;
    end
    assert (exp_q[k].size() > 0) else begin
      err_data++;
      $display("[FAIL] %0t: flit %h from port %0d VC %0d was never sent", $time, got, p, vc);
      return;
    end
    assert (got == exp_q[k][0]) else begin
      err_data++;
      $display("[FAIL] %0t: port %0d VC %0d got %h, expected %h", $time, p, vc, got,
               exp_q[k][0]);
    end
    // driven at edge n, out_valid high from edge n+3, sampled at n+4
    if (row.count == 1) begin
      assert (cycle - sent_edge_q[k][0] == 4) else begin
        err_data++;
        $display("[FAIL] %0t: latency %0d edges, expected 4", $time, cycle - sent_edge_q[k][0]);
      end
    end
    assert (cred_pend[p] && cred_edge[p] == cycle - 1 && cred_vc[p] == vc) else begin
      err_data++;
      $display("[FAIL] %0t: no upstream credit for VC %0d on port %0d one cycle before",
               $time, vc, p);
    end
    cred_pend[p] = 1'b0;
    if (row.port_mask == 2'b11 && row.vc < vc_router_pkg::NumVC) begin
      assert (prev_port != p) else begin
        err_data++;
        $display("[FAIL] %0t: port %0d won twice in a row", $time, p);
      end
      prev_port = p;
    end
    if (credits_held()) begin
      held_out[vc]++;
      assert (held_out[vc] <= vc_router_pkg::VCDepth) else begin
        err_data++;
        $display("[FAIL] %0t: %0d flits left on VC %0d without credit", $time, held_out[vc], vc);
      end
    end
    sink_vc_q.push_back(vc);
    sink_due_q.push_back(cycle + int'(row.delay) +
                         ((row.delay > 0) ? $unsigned($random(seed)) % (row.delay + 1) : 0));
    exp_q[k].pop_front();
    sent_edge_q[k].pop_front();
  endtask

  // downstream sink, one credit per cycle once its delay has passed
  task automatic return_credits();
    if (sink_vc_q.size() > 0 && !credits_held() && sink_due_q[0] <= cycle) begin
      out_credit_v_i  <= 1'b1;
      out_credit_id_i <= vc_router_pkg::NumVCWidth'(sink_vc_q[0]);
      sink_vc_q.pop_front();
      sink_due_q.pop_front();
    end
  endtask

  always @(posedge clk_i) begin
    if (cycle >= cycle_limit) begin
      $display("timeout after %0d cycles, the traffic did not drain", cycle);
      $display("Errors found");
      $finish;
    end else begin
      rst_n_i        <= (cycle >= 3);
      in_valid_i     <= '{default: 1'b0};
      out_credit_v_i <= 1'b0;
      if (cycle == 0) begin
        init_state();
      end
      if (cycle >= 1 && cycle <= 5) begin
        for (int p = 0; p < vc_router_pkg::NumInPorts; p++) begin
          assert (!out_valid_o && !in_credit_v_o[p]) else begin
            err_data++;
            $display("[FAIL] %0t: output or credit active around reset", $time);
          end
        end
      end
      if (out_valid_o) begin
        score_output();
      end
      for (int p = 0; p < vc_router_pkg::NumInPorts; p++) begin
        if (in_credit_v_o[p]) begin
          src_credit[p][in_credit_id_o[p]]++;
          upcred_cnt[p][in_credit_id_o[p]]++;
          cred_pend[p] = 1'b1;
          cred_edge[p] = cycle;
          cred_vc[p]   = int'(in_credit_id_o[p]);
        end
      end
      if (!row_active && row_req != row_cur) begin
        start_row();
      end
      if (row_active) begin
        drive_sources();
        return_credits();
        if (row_drained()) begin
          row_active = 1'b0;
          rows_done  = row_cur;
        end
      end
      cycle++;
    end
  end

  initial begin
    int limit;
    limit = 200;
    for (int r = 0; r < NumRows; r++) begin
      limit += 10 * (int'(Rows[r].count) + int'(Rows[r].delay));
    end
    cycle_limit = limit;
    repeat (8) @(negedge clk_i);
    for (int r = 0; r < NumRows; r++) begin
      row_req = r + 1;
      if (Rows[r].hold) begin
        repeat (HoldWindow) @(negedge clk_i);
        assert (held_out[Rows[r].vc] == vc_router_pkg::VCDepth) else begin
          err_ctrl++;
          $display("[FAIL] %0t: %0d flits left while credits were held, expected %0d",
                   $time, held_out[Rows[r].vc], vc_router_pkg::VCDepth);
        end
        release_req = r + 1;
      end
      wait (rows_done == r + 1);
      repeat (4) @(negedge clk_i);
    end
    for (int p = 0; p < vc_router_pkg::NumInPorts; p++) begin
      for (int v = 0; v < vc_router_pkg::NumVC; v++) begin
        assert (upcred_cnt[p][v] == sent_cnt[p][v]) else begin
          err_ctrl++;
          $display("[FAIL] %0t: port %0d VC %0d got %0d credits for %0d flits", $time, p, v,
                   upcred_cnt[p][v], sent_cnt[p][v]);
        end
      end
    end
    $display("run complete, %0d data errors, %0d control errors", err_data, err_ctrl);
    if (err_data + err_ctrl == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vc_router.f
rtl/vc_router_pkg.sv
rtl/port_alloc_if.sv
rtl/vc_fifo.sv
rtl/vc_input_port.sv
rtl/vc_switch_alloc.sv
rtl/vc_output_port.sv
rtl/vc_router.sv
sim/tb_vc_router.sv

// File: Bender.yml
package:
  name: vc_router

sources:
  - rtl/vc_router_pkg.sv
  - rtl/port_alloc_if.sv
  - rtl/vc_fifo.sv
  - rtl/vc_input_port.sv
  - rtl/vc_switch_alloc.sv
  - rtl/vc_output_port.sv
  - rtl/vc_router.sv
  - target: simulation
    files:
      - sim/tb_vc_router.sv
